/* csr_file.f */
rtl/csr_pkg.sv
rtl/csr_write_if.sv
rtl/csr_exc_regs.sv
rtl/csr_timer.sv
rtl/csr_save_regs.sv
rtl/csr_file.sv
sim/csr_file_monitor.sv
sim/csr_file_checker.sv
sim/csr_file_tb.sv

/* Bender.yml */
package:
  name: csr_file

sources:
  - rtl/csr_pkg.sv
  - rtl/csr_write_if.sv
  - rtl/csr_exc_regs.sv
  - rtl/csr_timer.sv
  - rtl/csr_save_regs.sv
  - rtl/csr_file.sv
  - target: test
    files:
      - sim/csr_file_monitor.sv
      - sim/csr_file_checker.sv
      - sim/csr_file_tb.sv

/* sim/csr_file_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_file_tb import csr_pkg::*;
();

    typedef enum logic [2:0] {
        OP_IDLE, OP_WRITE, OP_READ, OP_EXC, OP_EXC_RET, OP_RET, OP_WAIT
    } op_t;

    typedef struct packed {
        op_t        op;
        csr_num_t   addr;
        word_t      mask;
        word_t      value;
        word_t      pc;
        word_t      vaddr;
        ecode_t     ecode;
        esubcode_t  subcode;
        logic [7:0] hwi;
        logic       ipi;
        word_t      exp;
        logic       exp_int;
        plv_t       exp_plv;
        ecode_t     exp_ecode;
        word_t      exp_era;
        logic       era_valid;
        logic [7:0] limit;
    } step_t;

    logic       clk;
    logic       reset;
    csr_num_t   csr_num;
    logic       csr_we;
    word_t      csr_wmask;
    word_t      csr_wvalue;
    word_t      csr_rvalue;
    logic       wb_ex;
    word_t      wb_pc;
    ecode_t     wb_ecode;
    esubcode_t  wb_esubcode;
    word_t      wb_vaddr;
    logic       ertn_flush;
    logic [7:0] hw_int_in;
    logic       ipi_int_in;
    word_t      ertn_pc;
    word_t      ex_entry;
    logic       has_int;
    plv_t       crmd_plv;
    ecode_t     stat_ecode;

    // expected values handed to the monitor
    logic       check;
    word_t      exp_rvalue;
    logic       exp_int;
    plv_t       exp_plv;
    ecode_t     exp_ecode;
    word_t      exp_era;
    logic       era_valid;
    int         mon_errors;
    int         timeouts;
    int         assert_errors;

    step_t      steps[$];

    // reference state of the mode and exception fields
    plv_t       m_plv = '0;
    logic       m_ie = 1'b0;
    plv_t       m_pplv = '0;
    logic       m_pie = 1'b0;
    ecode_t     m_ecode = '0;
    esubcode_t  m_sub = '0;
    word_t      m_era = '0;
    logic       m_era_valid = 1'b0;
    logic [7:0] cur_hwi = '0;
    logic       cur_ipi = 1'b0;

    csr_file dut
    (
        .clk         (clk),
        .reset       (reset),
        .csr_num     (csr_num),
        .csr_we      (csr_we),
        .csr_wmask   (csr_wmask),
        .csr_wvalue  (csr_wvalue),
        .csr_rvalue  (csr_rvalue),
        .wb_ex       (wb_ex),
        .wb_pc       (wb_pc),
        .wb_ecode    (wb_ecode),
        .wb_esubcode (wb_esubcode),
        .wb_vaddr    (wb_vaddr),
        .ertn_flush  (ertn_flush),
        .hw_int_in   (hw_int_in),
        .ipi_int_in  (ipi_int_in),
        .ertn_pc     (ertn_pc),
        .ex_entry    (ex_entry),
        .has_int     (has_int),
        .crmd_plv    (crmd_plv),
        .stat_ecode  (stat_ecode)
    );

    csr_file_monitor mon
    (
        .clk        (clk),
        .check      (check),
        .csr_num    (csr_num),
        .exp_rvalue (exp_rvalue),
        .exp_int    (exp_int),
        .exp_plv    (exp_plv),
        .exp_ecode  (exp_ecode),
        .exp_era    (exp_era),
        .era_valid  (era_valid),
        .csr_rvalue (csr_rvalue),
        .has_int    (has_int),
        .crmd_plv   (crmd_plv),
        .stat_ecode (stat_ecode),
        .ertn_pc    (ertn_pc),
        .ex_entry   (ex_entry),
        .errors     (mon_errors)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic word_t merge_bits(word_t old_v, word_t mask, word_t val);
        word_t r;
        for (int b = 0; b < 32; b++)
            r[b] = mask[b] ? val[b] : old_v[b];
        return r;
    endfunction

    function automatic word_t crmd_image();
        return {29'b0, m_ie, m_plv};
    endfunction

    function automatic word_t prmd_image();
        return {29'b0, m_pie, m_pplv};
    endfunction

    // interrupt status in the low bits with code and subcode of the last exception
    function automatic word_t estat_image(logic [12:0] is_bits);
        word_t r;
        r = '0;
        r[12:0]  = is_bits;
        r[21:16] = m_ecode;
        r[30:22] = m_sub;
        return r;
    endfunction

    task automatic push(input op_t op, input csr_num_t addr, input word_t mask,
                        input word_t value, input word_t pc, input word_t vaddr,
                        input ecode_t ecode, input esubcode_t sub, input word_t exp,
                        input logic exp_int_v, input logic [7:0] limit);
        step_t s;
        s = '0;
        s.op        = op;
        s.addr      = addr;
        s.mask      = mask;
        s.value     = value;
        s.pc        = pc;
        s.vaddr     = vaddr;
        s.ecode     = ecode;
        s.subcode   = sub;
        s.hwi       = cur_hwi;
        s.ipi       = cur_ipi;
        s.exp       = exp;
        s.exp_int   = exp_int_v;
        s.exp_plv   = m_plv;
        s.exp_ecode = m_ecode;
        s.exp_era   = m_era;
        s.era_valid = m_era_valid;
        s.limit     = limit;
        steps.push_back(s);
    endtask

    task automatic add_write(input csr_num_t addr, input word_t mask, input word_t value);
        word_t nxt;
        push(OP_WRITE, addr, mask, value, '0, '0, '0, '0, '0, 1'b0, '0);
        if (addr == CSR_CRMD)
        begin
            nxt = merge_bits(crmd_image(), mask, value);
            {m_ie, m_plv} = nxt[2:0];
        end
        else if (addr == CSR_PRMD)
        begin
            nxt = merge_bits(prmd_image(), mask, value);
            {m_pie, m_pplv} = nxt[2:0];
        end
    endtask

    task automatic add_read(input csr_num_t addr, input word_t exp, input logic exp_int_v);
        push(OP_READ, addr, '0, '0, '0, '0, '0, '0, exp, exp_int_v, '0);
    endtask

    // with_ret raises ertn_flush in the same cycle and the exception still wins
    task automatic add_exc(input word_t pc, input word_t vaddr, input ecode_t ecode,
                           input esubcode_t sub, input logic with_ret);
        push(with_ret ? OP_EXC_RET : OP_EXC, '0, '0, '0, pc, vaddr, ecode, sub, '0, 1'b0, '0);
        m_pplv      = m_plv;
        m_pie       = m_ie;
        m_plv       = '0;
        m_ie        = 1'b0;
        m_ecode     = ecode;
        m_sub       = sub;
        m_era       = pc;
        m_era_valid = 1'b1;
    endtask

    task automatic add_ret();
        push(OP_RET, '0, '0, '0, '0, '0, '0, '0, '0, 1'b0, '0);
        m_plv = m_pplv;
        m_ie  = m_pie;
    endtask

    // a zero mask waits on has_int alone
    task automatic add_wait(input csr_num_t addr, input word_t mask, input word_t value,
                            input logic exp_int_v, input logic [7:0] limit);
        push(OP_WAIT, addr, mask, value, '0, '0, '0, '0, '0, exp_int_v, limit);
    endtask

    task automatic build_steps();
        word_t first;
        word_t mask;
        word_t val;
        add_read(CSR_CRMD, crmd_image(), 1'b0);

        for (int i = 0; i < 4; i++)
        begin
            first = $urandom;
            mask  = $urandom;
            val   = $urandom;
            add_write(csr_num_t'(CSR_SAVE0 + i), '1, first);
            add_write(csr_num_t'(CSR_SAVE0 + i), mask, val);
            add_read(csr_num_t'(CSR_SAVE0 + i), merge_bits(first, mask, val), 1'b0);
        end

        // enables end up on swi0 and hwi0
        add_write(CSR_ECFG, '1, 32'h0000_0006);
        add_read(CSR_ECFG, 32'h0000_0006, 1'b0);
        add_write(CSR_ECFG, 32'h0000_0003, 32'h0000_0001);
        add_read(CSR_ECFG, merge_bits(32'h6, 32'h3, 32'h1), 1'b0);

        add_write(CSR_EENTRY, '1, 32'h1c00_0fff);
        add_read(CSR_EENTRY, 32'h1c00_0fc0, 1'b0);
        add_write(CSR_EENTRY, 32'h0000_ff00, 32'h0000_a5a5);
        add_read(CSR_EENTRY,
                 merge_bits(32'h1c00_0fc0, 32'h0000_ff00, 32'h0000_a5a5) & ~32'h3f, 1'b0);

        add_write(CSR_CRMD, 32'h7, 32'h7);
        add_read(CSR_CRMD, crmd_image(), 1'b0);
        add_exc(32'h1c00_1000, 32'h0000_beef, ECODE_ALE, 9'h0, 1'b0);
        add_read(CSR_PRMD, prmd_image(), 1'b0);
        add_read(CSR_CRMD, crmd_image(), 1'b0);
        add_read(CSR_ERA, m_era, 1'b0);
        add_read(CSR_BADV, 32'h0000_beef, 1'b0);
        add_read(CSR_ESTAT, estat_image('0), 1'b0);
        // fetch fault records the pc
        add_exc(32'h1c00_2000, 32'h1234_5678, ECODE_ADE, ESUBCODE_ADEF, 1'b0);
        add_read(CSR_BADV, 32'h1c00_2000, 1'b0);
        add_read(CSR_ESTAT, estat_image('0), 1'b0);
        add_exc(32'h1c00_3000, 32'h0bad_0bad, 6'hb, 9'h0, 1'b0);
        add_read(CSR_BADV, 32'h1c00_2000, 1'b0);
        add_read(CSR_ERA, m_era, 1'b0);

        add_write(CSR_PRMD, 32'h7, 32'h6);
        add_read(CSR_PRMD, prmd_image(), 1'b0);
        add_ret();
        add_read(CSR_CRMD, crmd_image(), 1'b0);
        add_exc(32'h1c00_4000, 32'h0, 6'hc, 9'h1, 1'b1);
        add_read(CSR_CRMD, crmd_image(), 1'b0);
        add_read(CSR_PRMD, prmd_image(), 1'b0);
        add_ret();
        add_read(CSR_CRMD, crmd_image(), 1'b0);

        // hwi1 is pending but not enabled
        cur_hwi = 8'h02;
        add_read(CSR_ECFG, 32'h0000_0005, 1'b0);
        add_read(CSR_ESTAT, estat_image(13'h008), 1'b0);
        cur_hwi = 8'h03;
        add_write(CSR_CRMD, 32'h4, 32'h0);
        add_read(CSR_ESTAT, estat_image(13'h00c), 1'b0);
        add_read(CSR_CRMD, crmd_image(), 1'b0);
        add_write(CSR_CRMD, 32'h4, 32'h4);
        add_wait(CSR_CRMD, 32'h0, 32'h0, 1'b1, 8'd4);
        add_read(CSR_CRMD, crmd_image(), 1'b1);
        cur_hwi = 8'h00;
        add_write(CSR_ESTAT, 32'h3, 32'h1);
        add_read(CSR_ESTAT, estat_image(13'h001), 1'b1);
        add_write(CSR_ESTAT, 32'h3, 32'h0);
        add_read(CSR_ESTAT, estat_image('0), 1'b0);

        // ipi is sampled like the hardware lines and stays out of has_int
        cur_ipi = 1'b1;
        add_read(CSR_ECFG, 32'h0000_0005, 1'b0);
        add_read(CSR_ESTAT, estat_image(13'h1000), 1'b0);
        cur_ipi = 1'b0;
        add_read(CSR_ESTAT, estat_image(13'h1000), 1'b0);
        add_read(CSR_ESTAT, estat_image('0), 1'b0);

        // one-shot countdown from 5 * 4 with the timer interrupt disabled in ECFG
        add_write(CSR_TCFG, '1, {30'd5, 2'b01});
        add_read(CSR_TCFG, {30'd5, 2'b01}, 1'b0);
        add_read(CSR_TVAL, 32'd5 * 4 - 1, 1'b0);
        add_read(CSR_TVAL, 32'd5 * 4 - 2, 1'b0);
        // budget counts from the TCFG write three cycles back
        add_wait(CSR_ESTAT, 32'h800, 32'h800, 1'b0, 8'd5 * 4 + 2 - 3);
        add_read(CSR_ESTAT, estat_image(13'h800), 1'b0);
        add_write(CSR_TICLR, 32'h1, 32'h1);
        add_read(CSR_ESTAT, estat_image('0), 1'b0);
        add_read(CSR_TVAL, TIMER_IDLE, 1'b0);
        add_read(CSR_TICLR, '0, 1'b0);
        add_read(CSR_ESTAT, estat_image('0), 1'b0);
    endtask

    task automatic apply_step(input step_t s);
        csr_num     = s.addr;
        csr_we      = (s.op == OP_WRITE);
        csr_wmask   = s.mask;
        csr_wvalue  = s.value;
        wb_ex       = (s.op == OP_EXC) || (s.op == OP_EXC_RET);
        ertn_flush  = (s.op == OP_RET) || (s.op == OP_EXC_RET);
        wb_pc       = s.pc;
        wb_vaddr    = s.vaddr;
        wb_ecode    = s.ecode;
        wb_esubcode = s.subcode;
        hw_int_in   = s.hwi;
        ipi_int_in  = s.ipi;
        check       = (s.op == OP_READ);
        exp_rvalue  = s.exp;
        exp_int     = s.exp_int;
        exp_plv     = s.exp_plv;
        exp_ecode   = s.exp_ecode;
        exp_era     = s.exp_era;
        era_valid   = s.era_valid;
    endtask

    task automatic wait_for_match(input step_t s);
        int   n;
        logic matched;
        n = 0;
        matched = 1'b0;
        while (!matched && n < s.limit)
        begin
            @(posedge clk);
            n++;
            matched = ((csr_rvalue & s.mask) === (s.value & s.mask)) && (has_int === s.exp_int);
        end
        if (!matched)
        begin
            timeouts++;
            if (s.mask == '0)
                $display("timeout: has_int never went to %0b within %0d cycles",
                         s.exp_int, s.limit);
            else
                $display("timeout: csr 0x%03h bits 0x%08h never reached 0x%08h in %0d cycles",
                         s.addr, s.mask, s.value, s.limit);
        end
    endtask

    initial
    begin
        timeouts = 0;
        void'($urandom(69));
        ipi_int_in = 1'b0;
        reset = 1'b1;
        apply_step('0);
        build_steps();
        repeat (10) @(negedge clk);
        reset = 1'b0;

        foreach (steps[i])
        begin
            @(negedge clk);
            apply_step(steps[i]);
            if (steps[i].op == OP_WAIT)
                wait_for_match(steps[i]);
        end

        @(negedge clk);
        apply_step('0);
        @(negedge clk);
        assert_errors = dut.u_exc_regs.chk.fail_count;
        $display("errors: %0d check, %0d assertion, %0d timeout",
                 mon_errors, assert_errors, timeouts);
        if (mon_errors == 0 && assert_errors == 0 && timeouts == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/csr_file_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_file_checker import csr_pkg::*;
(
    input  wire        clk,
    input  wire        reset,
    input  wire        wb_ex,
    input  wire plv_t  plv,
    input  wire        ie,
    input  wire        has_int
);

    int fail_count = 0;

    // handler always starts at plv0 with interrupts off
    exc_clears_mode: assert property (@(posedge clk) disable iff (reset)
        wb_ex |=> (plv == '0) && !ie)
    else
    begin
        fail_count++;
        $error("exception entry left plv or ie set");
    end

    no_int_when_masked: assert property (@(posedge clk) disable iff (reset)
        !ie |-> !has_int)
    else
    begin
        fail_count++;
        $error("has_int high with crmd ie clear");
    end

endmodule

bind csr_exc_regs csr_file_checker chk
(
    .clk     (clk),
    .reset   (reset),
    .wb_ex   (wb_ex),
    .plv     (crmd_plv_q),
    .ie      (crmd_ie_q),
    .has_int (has_int)
);

`default_nettype wire

/* sim/csr_file_monitor.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_file_monitor import csr_pkg::*;
(
    input  wire            clk,
    input  wire            check,
    input  wire csr_num_t  csr_num,
    input  wire word_t     exp_rvalue,
    input  wire            exp_int,
    input  wire plv_t      exp_plv,
    input  wire ecode_t    exp_ecode,
    input  wire word_t     exp_era,
    input  wire            era_valid,
    input  wire word_t     csr_rvalue,
    input  wire            has_int,
    input  wire plv_t      crmd_plv,
    input  wire ecode_t    stat_ecode,
    input  wire word_t     ertn_pc,
    input  wire word_t     ex_entry,
    output int             errors
);

    int err_count = 0;

    assign errors = err_count;

    task automatic flag_mismatch(input string what, input word_t got, input word_t want);
        $display("[FAIL] %0t: %s is 0x%08h, expected 0x%08h (csr 0x%03h)",
                 $time, what, got, want, csr_num);
        err_count++;
    endtask

    // outputs are settled from the falling edge, registers not yet updated
    always @(posedge clk)
    begin
        if (check)
        begin
            if (csr_rvalue !== exp_rvalue)
                flag_mismatch("csr_rvalue", csr_rvalue, exp_rvalue);
            if (has_int !== exp_int)
                flag_mismatch("has_int", word_t'(has_int), word_t'(exp_int));
            if (crmd_plv !== exp_plv)
                flag_mismatch("crmd_plv", word_t'(crmd_plv), word_t'(exp_plv));
            if (stat_ecode !== exp_ecode)
                flag_mismatch("stat_ecode", word_t'(stat_ecode), word_t'(exp_ecode));
            // era is undefined until the first exception
            if (era_valid && ertn_pc !== exp_era)
                flag_mismatch("ertn_pc", ertn_pc, exp_era);
            if (csr_num == CSR_EENTRY && ex_entry !== exp_rvalue)
                flag_mismatch("ex_entry", ex_entry, exp_rvalue);
        end
    end

endmodule

`default_nettype wire

/* rtl/csr_file.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_file import csr_pkg::*;
(
    input  wire                clk,
    input  wire                reset,

    input  wire csr_num_t      csr_num,
    input  wire                csr_we,
    input  wire word_t         csr_wmask,
    input  wire word_t         csr_wvalue,
    output word_t              csr_rvalue,

    input  wire                wb_ex,
    input  wire word_t         wb_pc,
    input  wire ecode_t        wb_ecode,
    input  wire esubcode_t     wb_esubcode,
    input  wire word_t         wb_vaddr,
    input  wire                ertn_flush,
    input  wire [HWI_NUM-1:0]  hw_int_in,
    input  wire                ipi_int_in,

    output word_t              ertn_pc,
    output word_t              ex_entry,
    output logic               has_int,
    output plv_t               crmd_plv,
    output ecode_t             stat_ecode
);

    word_t exc_rdata;
    word_t timer_rdata;
    word_t save_rdata;
    logic  timer_irq;

    csr_write_if wr ();

    assign wr.we     = csr_we;
    assign wr.num    = csr_num;
    assign wr.wmask  = csr_wmask;
    assign wr.wvalue = csr_wvalue;

    csr_exc_regs u_exc_regs
    (
        .clk         (clk),
        .reset       (reset),
        .wr          (wr),
        .wb_ex       (wb_ex),
        .wb_pc       (wb_pc),
        .wb_ecode    (wb_ecode),
        .wb_esubcode (wb_esubcode),
        .wb_vaddr    (wb_vaddr),
        .ertn_flush  (ertn_flush),
        .hw_int_in   (hw_int_in),
        .ipi_int_in  (ipi_int_in),
        .timer_irq   (timer_irq),
        .rdata       (exc_rdata),
        .ertn_pc     (ertn_pc),
        .ex_entry    (ex_entry),
        .has_int     (has_int),
        .crmd_plv    (crmd_plv),
        .stat_ecode  (stat_ecode)
    );

    csr_timer u_timer
    (
        .clk       (clk),
        .reset     (reset),
        .wr        (wr),
        .rdata     (timer_rdata),
        .timer_irq (timer_irq)
    );

    csr_save_regs u_save_regs
    (
        .clk   (clk),
        .wr    (wr),
        .rdata (save_rdata)
    );

    // each block returns zero outside its own addresses
    assign csr_rvalue = exc_rdata | timer_rdata | save_rdata;

endmodule

`default_nettype wire

/* rtl/csr_save_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_save_regs import csr_pkg::*;
(
    input  wire        clk,

    csr_write_if.sink  wr,

    output word_t      rdata
);

    word_t       save_q [4];
    logic        save_hit;
    logic [1:0]  save_idx;

    // scratch space for handlers, one decode shared by read and write
    always_comb
    begin
        save_hit = 1'b1;
        save_idx = 2'd0;
        case (wr.num)
            CSR_SAVE0: save_idx = 2'd0;
            CSR_SAVE1: save_idx = 2'd1;
            CSR_SAVE2: save_idx = 2'd2;
            CSR_SAVE3: save_idx = 2'd3;
            default:   save_hit = 1'b0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (wr.we && save_hit)
            save_q[save_idx] <= csr_merge(save_q[save_idx], wr.wmask, wr.wvalue);
    end

    assign rdata = save_hit ? save_q[save_idx] : '0;

endmodule

`default_nettype wire

/* rtl/csr_timer.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_timer import csr_pkg::*;
(
    input  wire        clk,
    input  wire        reset,

    csr_write_if.sink  wr,

    output word_t      rdata,
    output logic       timer_irq
);

    logic                       tcfg_en_q;
    logic                       tcfg_periodic_q;
    logic [31:TCFG_INITVAL_LSB] tcfg_initval_q;
    word_t                      timer_cnt;

    word_t                      tcfg_word;
    word_t                      tcfg_next;
    logic                       wr_tcfg;
    logic                       ticlr_clr;
    logic                       cnt_zero;

    always_comb
    begin
        tcfg_word = '0;
        tcfg_word[TCFG_EN] = tcfg_en_q;
        tcfg_word[TCFG_PERIODIC] = tcfg_periodic_q;
        tcfg_word[31:TCFG_INITVAL_LSB] = tcfg_initval_q;
    end

    // tcfg as it will be after this cycle's write, so the counter loads at once
    assign tcfg_next = csr_merge(tcfg_word, wr.wmask, wr.wvalue);
    assign wr_tcfg   = wr.we && (wr.num == CSR_TCFG);
    assign ticlr_clr = wr.we && (wr.num == CSR_TICLR)
                       && wr.wmask[TICLR_CLR] && wr.wvalue[TICLR_CLR];
    assign cnt_zero  = tcfg_en_q && (timer_cnt == '0);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            tcfg_en_q       <= 1'b0;
            tcfg_periodic_q <= 1'b0;
        end
        else if (wr_tcfg)
        begin
            tcfg_en_q       <= tcfg_next[TCFG_EN];
            tcfg_periodic_q <= tcfg_next[TCFG_PERIODIC];
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_tcfg)
            tcfg_initval_q <= tcfg_next[31:TCFG_INITVAL_LSB];
    end

    // one-shot expiry steps from zero to TIMER_IDLE and stops there
    always_ff @(posedge clk)
    begin
        if (reset)
            timer_cnt <= TIMER_IDLE;
        else if (wr_tcfg && tcfg_next[TCFG_EN])
            timer_cnt <= {tcfg_next[31:TCFG_INITVAL_LSB], {TCFG_INITVAL_LSB{1'b0}}};
        else if (tcfg_en_q && timer_cnt != TIMER_IDLE)
        begin
            if (cnt_zero && tcfg_periodic_q)
                timer_cnt <= {tcfg_initval_q, {TCFG_INITVAL_LSB{1'b0}}};
            else
                timer_cnt <= timer_cnt - 1'b1;
        end
    end

    // expiry wins over a clear in the same cycle
    always_ff @(posedge clk)
    begin
        if (reset)
            timer_irq <= 1'b0;
        else if (cnt_zero)
            timer_irq <= 1'b1;
        else if (ticlr_clr)
            timer_irq <= 1'b0;
    end

    // ticlr is write-only and falls into the zero default
    always_comb
    begin
        case (wr.num)
            CSR_TCFG: rdata = tcfg_word;
            CSR_TVAL: rdata = timer_cnt;
            default:  rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/csr_exc_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_exc_regs import csr_pkg::*;
(
    input  wire                clk,
    input  wire                reset,

    csr_write_if.sink          wr,

    input  wire                wb_ex,
    input  wire word_t         wb_pc,
    input  wire ecode_t        wb_ecode,
    input  wire esubcode_t     wb_esubcode,
    input  wire word_t         wb_vaddr,
    input  wire                ertn_flush,
    input  wire [HWI_NUM-1:0]  hw_int_in,
    input  wire                ipi_int_in,
    input  wire                timer_irq,

    output word_t              rdata,
    output word_t              ertn_pc,
    output word_t              ex_entry,
    output logic               has_int,
    output plv_t               crmd_plv,
    output ecode_t             stat_ecode
);

    plv_t                    crmd_plv_q;
    logic                    crmd_ie_q;
    plv_t                    prmd_pplv_q;
    logic                    prmd_pie_q;
    int_vec_t                ecfg_lie_q;
    logic [1:0]              estat_swi_q;
    logic [HWI_NUM-1:0]      estat_hwi_q;
    logic                    estat_ipi_q;
    ecode_t                  estat_ecode_q;
    esubcode_t               estat_esubcode_q;
    word_t                   era_q;
    word_t                   badv_q;
    logic [31:EENTRY_VA_LSB] eentry_va_q;

    word_t                   crmd_word;
    word_t                   prmd_word;
    word_t                   estat_word;
    word_t                   eentry_word;
    int_vec_t                estat_is;
    word_t                   wr_next;
    logic                    addr_err;
    logic                    fetch_err;

    // register images as software sees them
    always_comb
    begin
        crmd_word = '0;
        crmd_word[CRMD_PLV_LSB +: 2] = crmd_plv_q;
        crmd_word[CRMD_IE] = crmd_ie_q;

        prmd_word = '0;
        prmd_word[PRMD_PPLV_LSB +: 2] = prmd_pplv_q;
        prmd_word[PRMD_PIE] = prmd_pie_q;

        estat_is = '0;
        estat_is[ESTAT_SWI_LSB +: 2] = estat_swi_q;
        estat_is[ESTAT_HWI_LSB +: HWI_NUM] = estat_hwi_q;
        estat_is[ESTAT_TI] = timer_irq;
        estat_is[ESTAT_IPI] = estat_ipi_q;

        estat_word = '0;
        estat_word[ESTAT_IPI:0] = estat_is;
        estat_word[ESTAT_ECODE_LSB +: 6] = estat_ecode_q;
        estat_word[ESTAT_ESUBCODE_LSB +: 9] = estat_esubcode_q;

        eentry_word = '0;
        eentry_word[31:EENTRY_VA_LSB] = eentry_va_q;
    end

    // old contents of the addressed register merged with the write data
    assign wr_next = csr_merge(rdata, wr.wmask, wr.wvalue);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            crmd_plv_q <= '0;
            crmd_ie_q  <= 1'b0;
        end
        else if (wb_ex)
        begin
            // handler runs at plv0 with interrupts off
            crmd_plv_q <= '0;
            crmd_ie_q  <= 1'b0;
        end
        else if (ertn_flush)
        begin
            crmd_plv_q <= prmd_pplv_q;
            crmd_ie_q  <= prmd_pie_q;
        end
        else if (wr.we && wr.num == CSR_CRMD)
        begin
            crmd_plv_q <= wr_next[CRMD_PLV_LSB +: 2];
            crmd_ie_q  <= wr_next[CRMD_IE];
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            prmd_pplv_q <= '0;
            prmd_pie_q  <= 1'b0;
        end
        else if (wb_ex)
        begin
            prmd_pplv_q <= crmd_plv_q;
            prmd_pie_q  <= crmd_ie_q;
        end
        else if (wr.we && wr.num == CSR_PRMD)
        begin
            prmd_pplv_q <= wr_next[PRMD_PPLV_LSB +: 2];
            prmd_pie_q  <= wr_next[PRMD_PIE];
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            ecfg_lie_q <= '0;
        else if (wr.we && wr.num == CSR_ECFG)
            ecfg_lie_q <= wr_next[ESTAT_IPI:0];
    end

    // software bits are writable, hardware and ipi lines are sampled
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            estat_swi_q <= '0;
            estat_hwi_q <= '0;
            estat_ipi_q <= 1'b0;
        end
        else
        begin
            if (wr.we && wr.num == CSR_ESTAT)
                estat_swi_q <= wr_next[ESTAT_SWI_LSB +: 2];
            estat_hwi_q <= hw_int_in;
            estat_ipi_q <= ipi_int_in;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            estat_ecode_q    <= '0;
            estat_esubcode_q <= '0;
        end
        else if (wb_ex)
        begin
            estat_ecode_q    <= wb_ecode;
            estat_esubcode_q <= wb_esubcode;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wb_ex)
            era_q <= wb_pc;
        else if (wr.we && wr.num == CSR_ERA)
            era_q <= wr_next;
    end

    // a fetch fault reports the pc, a data fault the access address
    assign addr_err  = (wb_ecode == ECODE_ADE) || (wb_ecode == ECODE_ALE);
    assign fetch_err = (wb_ecode == ECODE_ADE) && (wb_esubcode == ESUBCODE_ADEF);

    always_ff @(posedge clk)
    begin
        if (wb_ex && addr_err)
            badv_q <= fetch_err ? wb_pc : wb_vaddr;
    end

    always_ff @(posedge clk)
    begin
        if (wr.we && wr.num == CSR_EENTRY)
            eentry_va_q <= wr_next[31:EENTRY_VA_LSB];
    end

    always_comb
    begin
        case (wr.num)
            CSR_CRMD:   rdata = crmd_word;
            CSR_PRMD:   rdata = prmd_word;
            CSR_ECFG:   rdata = word_t'(ecfg_lie_q);
            CSR_ESTAT:  rdata = estat_word;
            CSR_ERA:    rdata = era_q;
            CSR_BADV:   rdata = badv_q;
            CSR_EENTRY: rdata = eentry_word;
            default:    rdata = '0;
        endcase
    end

    assign ertn_pc    = era_q;
    assign ex_entry   = eentry_word;
    assign crmd_plv   = crmd_plv_q;
    assign stat_ecode = estat_ecode_q;

    // pending and locally enabled, gated by the global enable
    assign has_int = (|(estat_is[ESTAT_TI:0] & ecfg_lie_q[ESTAT_TI:0])) && crmd_ie_q;

endmodule

`default_nettype wire

/* rtl/csr_write_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface csr_write_if import csr_pkg::*; ();

    logic     we;
    csr_num_t num;
    word_t    wmask;
    word_t    wvalue;

    // driven from the top-level ports
    modport src
    (
        output we, num, wmask, wvalue
    );

    // register blocks decode their own addresses
    modport sink
    (
        input we, num, wmask, wvalue
    );

endinterface

`default_nettype wire

/* rtl/csr_pkg.sv */
`default_nettype none

package csr_pkg;

    typedef logic [13:0] csr_num_t;
    typedef logic [31:0] word_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;
    typedef logic [1:0]  plv_t;
    typedef logic [12:0] int_vec_t;

    // csr addresses
    localparam csr_num_t CSR_CRMD   = 14'h0;
    localparam csr_num_t CSR_PRMD   = 14'h1;
    localparam csr_num_t CSR_ECFG   = 14'h4;
    localparam csr_num_t CSR_ESTAT  = 14'h5;
    localparam csr_num_t CSR_ERA    = 14'h6;
    localparam csr_num_t CSR_BADV   = 14'h7;
    localparam csr_num_t CSR_EENTRY = 14'hc;
    localparam csr_num_t CSR_SAVE0  = 14'h30;
    localparam csr_num_t CSR_SAVE1  = 14'h31;
    localparam csr_num_t CSR_SAVE2  = 14'h32;
    localparam csr_num_t CSR_SAVE3  = 14'h33;
    localparam csr_num_t CSR_TCFG   = 14'h41;
    localparam csr_num_t CSR_TVAL   = 14'h42;
    localparam csr_num_t CSR_TICLR  = 14'h44;

    // field positions, given as lsb where the field is wider than one bit
    localparam int CRMD_PLV_LSB       = 0;
    localparam int CRMD_IE            = 2;
    localparam int PRMD_PPLV_LSB      = 0;
    localparam int PRMD_PIE           = 2;
    localparam int ESTAT_SWI_LSB      = 0;
    localparam int ESTAT_HWI_LSB      = 2;
    localparam int ESTAT_TI           = 11;
    localparam int ESTAT_IPI          = 12;
    localparam int ESTAT_ECODE_LSB    = 16;
    localparam int ESTAT_ESUBCODE_LSB = 22;
    localparam int TCFG_EN            = 0;
    localparam int TCFG_PERIODIC      = 1;
    localparam int TCFG_INITVAL_LSB   = 2;
    localparam int TICLR_CLR          = 0;
    localparam int EENTRY_VA_LSB      = 6;

    // number of hardware interrupt lines
    localparam int HWI_NUM = 8;

    localparam ecode_t    ECODE_ADE     = 6'h8;
    localparam ecode_t    ECODE_ALE     = 6'h9;
    localparam esubcode_t ESUBCODE_ADEF = 9'h0;

    // counter parks here once a one-shot countdown has expired
    localparam word_t TIMER_IDLE = 32'hffff_ffff;

    // bits set in the mask come from the new value, the rest keep the old one
    function automatic word_t csr_merge(word_t old_val, word_t wmask, word_t wvalue);
        return (wmask & wvalue) | (~wmask & old_val);
    endfunction

endpackage

`default_nettype wire
